//--- hw/mixer_defines.svh
`ifndef MIXER_DEFINES_SVH
`define MIXER_DEFINES_SVH

// number of mono sources and its base-2 log.
`define MIX_NUM_CH      4
`define MIX_NUM_CH_LOG2 2

// frame length in clocks; must exceed 2*MIX_NUM_CH+7.
`define MIX_FS          256

// samples held per source FIFO as a power of two.
`define MIX_FIFO_DEPTH  4

// wishbone word address and data widths.
`define MIX_WB_AW       2
`define MIX_WB_DW       32

`endif

//--- hw/mixer_pkg.sv
`include "mixer_defines.svh"

package mixer_pkg;

    typedef logic signed [23:0] sample_t; // one two's complement audio sample.

    typedef logic [15:0] vol_t; // unsigned Q1.15 gain where 0x8000 is unity.

    typedef struct packed {
        vol_t right; // upper halfword of the bus word.
        vol_t left;
    } vol_pair_t;

    typedef struct packed {
        logic                        valid;
        logic [`MIX_NUM_CH_LOG2-1:0] src;
        sample_t                     data;
    } src_push_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`MIX_WB_AW-1:0] adr; // word address with one pair per source.
        logic [`MIX_WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [`MIX_WB_DW-1:0] dat;
    } wb_rsp_t;

endpackage

//--- hw/mpemu_scale.sv
`timescale 1ns/10ps

module mpemu_scale (
    input  logic               clk,
    input  logic signed [23:0] mpcand_i,
    input  logic        [15:0] scale_i,
    output logic signed [23:0] mprod_o
);

    logic signed [23:0] s1_mpcand_q;
    logic        [7:0]  s1_scale_hi_q;
    logic signed [32:0] s1_pp_lo_q;
    logic signed [32:0] s2_pp_lo_q;
    logic signed [32:0] s2_pp_hi_q;
    logic signed [40:0] s3_sum_q;
    logic signed [23:0] s4_prod_q;

    // the low byte of the gain is multiplied first and the high byte a stage later.
    always_ff @(posedge clk) begin
        s1_mpcand_q   <= mpcand_i;
        s1_scale_hi_q <= scale_i[15:8];
        s1_pp_lo_q    <= mpcand_i * $signed({1'b0, scale_i[7:0]});
    end

    always_ff @(posedge clk) begin
        s2_pp_lo_q <= s1_pp_lo_q;
        s2_pp_hi_q <= s1_mpcand_q * $signed({1'b0, s1_scale_hi_q});
    end

    always_ff @(posedge clk) begin
        s3_sum_q <= $signed({s2_pp_hi_q, 8'd0}) + s2_pp_lo_q;
    end

    // the sum is shifted right by 15 and cut to 24 bits.
    always_ff @(posedge clk) begin
        s4_prod_q <= s3_sum_q[38:15];
    end

    assign mprod_o = s4_prod_q;

endmodule

//--- hw/src_fifo.sv
`timescale 1ns/10ps
`include "mixer_defines.svh"

module src_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push_i,
    input  mixer_pkg::sample_t sample_i,
    input  logic               pop_i,
    output mixer_pkg::sample_t head_o,
    output logic               full_o
);

    localparam int DEPTH = `MIX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    mixer_pkg::sample_t mem [0:DEPTH-1];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    mixer_pkg::sample_t head_q;
    logic               empty;
    logic               do_push;
    logic               do_read;

    assign empty   = (count_q == '0);
    assign full_o  = (count_q == CNT_FULL);
    assign do_read = pop_i && !empty;
    assign do_push = push_i && (!full_o || pop_i); // a pop frees a slot in the same clock.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= sample_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // the head only moves on a frame pop, so the mixer sees it steady all frame.
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
        end else if (pop_i) begin
            head_q <= empty ? '0 : mem[rd_ptr_q]; // underrun mixes as silence.
        end
    end

    assign head_o = head_q;

endmodule

//--- hw/vol_regs.sv
`timescale 1ns/10ps
`include "mixer_defines.svh"

module vol_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  mixer_pkg::wb_req_t   wb_req_i,
    output mixer_pkg::wb_rsp_t   wb_rsp_o,
    output mixer_pkg::vol_pair_t vol_o [0:`MIX_NUM_CH-1]
);

    localparam mixer_pkg::vol_t VOL_UNITY = 16'h8000;
    localparam mixer_pkg::vol_pair_t VOL_RESET = '{right: VOL_UNITY, left: VOL_UNITY};

    logic                  req_active;
    logic                  req_new;
    logic                  ack_q;
    logic [`MIX_WB_DW-1:0] rdata_q;
    mixer_pkg::vol_pair_t  vol_q [0:`MIX_NUM_CH-1];

    assign req_active = wb_req_i.cyc && wb_req_i.stb;
    assign req_new    = req_active && !ack_q; // no second ack while stb is still up.

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIX_NUM_CH; i++) begin
                vol_q[i] <= VOL_RESET;
            end
        end else if (req_new && wb_req_i.we) begin
            vol_q[wb_req_i.adr] <= wb_req_i.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) begin
            rdata_q <= vol_q[wb_req_i.adr];
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};
    assign vol_o    = vol_q;

endmodule

//--- hw/mixer.sv
`timescale 1ns/10ps
`include "mixer_defines.svh"

module mixer (
    input  logic                   clk, // 24.576 MHz audio clock.
    input  logic                   rst,
    output logic [`MIX_NUM_CH-1:0] pop_o,
    input  mixer_pkg::sample_t     data_i [0:`MIX_NUM_CH-1],
    input  mixer_pkg::vol_pair_t   vol_i [0:`MIX_NUM_CH-1],
    input  logic [1:0]             pop_i,
    output mixer_pkg::sample_t     data_o,
    output logic [1:0]             ack_o
);

    localparam int PHASE_W   = $clog2(`MIX_FS);
    localparam int SLOT_W    = `MIX_NUM_CH_LOG2 + 1;
    localparam int NUM_SLOTS = 2 * `MIX_NUM_CH;
    localparam logic [PHASE_W-1:0] PHASE_END = PHASE_W'(`MIX_FS - 1);
    localparam logic [PHASE_W-1:0] SLOT_END  = PHASE_W'(NUM_SLOTS);
    localparam logic [PHASE_W-1:0] MAC_DELAY = PHASE_W'(6);

    logic [PHASE_W-1:0]          phase_q;
    logic                        pop_q;
    logic [SLOT_W-1:0]           slot;
    logic [`MIX_NUM_CH_LOG2-1:0] slot_src;
    mixer_pkg::vol_pair_t        slot_vol;
    mixer_pkg::sample_t          data_mux_q;
    mixer_pkg::vol_t             vol_mux_q;
    mixer_pkg::sample_t          prod;
    mixer_pkg::sample_t          prod_q;
    logic [PHASE_W-1:0]          mac_phase;
    logic                        mac_sel;
    mixer_pkg::sample_t          acc_q [0:1];
    mixer_pkg::sample_t          out_q [0:1];
    logic                        chsel_q;
    logic [1:0]                  ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= '0;
        end else if (phase_q == PHASE_END) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // high during the last phase so the heads change right at the frame boundary.
    always_ff @(posedge clk) begin
        if (rst) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= (phase_q == PHASE_END - 1'b1);
        end
    end

    assign pop_o = {`MIX_NUM_CH{pop_q}};

    // even slots take the left gain and odd slots the right gain of source slot/2.
    assign slot     = phase_q[SLOT_W-1:0];
    assign slot_src = slot[SLOT_W-1:1];
    assign slot_vol = vol_i[slot_src];

    always_ff @(posedge clk) begin
        if (rst) begin
            data_mux_q <= '0;
            vol_mux_q  <= '0;
        end else if (phase_q < SLOT_END) begin
            data_mux_q <= data_i[slot_src];
            vol_mux_q  <= slot[0] ? slot_vol.right : slot_vol.left;
        end else begin
            data_mux_q <= '0;
            vol_mux_q  <= '0;
        end
    end

    mpemu_scale i_scale (
        .clk      (clk),
        .mpcand_i (data_mux_q),
        .scale_i  (vol_mux_q),
        .mprod_o  (prod)
    );

    // one more register brings slot k to the adder in phase k+6.
    always_ff @(posedge clk) begin
        prod_q <= prod;
    end

    assign mac_phase = phase_q - MAC_DELAY;
    assign mac_sel   = mac_phase[0];

    // the sum wraps modulo 2^24.
    always_ff @(posedge clk) begin
        if (phase_q == '0) begin
            acc_q[0] <= '0;
            acc_q[1] <= '0;
        end else begin
            acc_q[mac_sel] <= acc_q[mac_sel] + prod_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_q[0] <= '0;
            out_q[1] <= '0;
        end else if (phase_q == PHASE_END) begin
            out_q[0] <= acc_q[0];
            out_q[1] <= acc_q[1];
        end
    end

    // left wins when both sides are requested.
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q   <= 2'b00;
            chsel_q <= 1'b0;
        end else begin
            ack_q <= 2'b00;
            if (pop_i[0]) begin
                chsel_q <= 1'b0;
                ack_q   <= 2'b01;
            end else if (pop_i[1]) begin
                chsel_q <= 1'b1;
                ack_q   <= 2'b10;
            end
        end
    end

    assign data_o = out_q[chsel_q];
    assign ack_o  = ack_q;

endmodule

//--- hw/mixer_top.sv
`timescale 1ns/10ps
`include "mixer_defines.svh"

module mixer_top (
    input  logic                   clk,
    input  logic                   rst,
    input  mixer_pkg::wb_req_t     wb_req_i,
    output mixer_pkg::wb_rsp_t     wb_rsp_o,
    input  mixer_pkg::src_push_t   src_push_i,
    output logic [`MIX_NUM_CH-1:0] src_full_o,
    input  logic [1:0]             snk_pop_i,
    output mixer_pkg::sample_t     snk_data_o,
    output logic [1:0]             snk_ack_o
);

    localparam int SRC_W = `MIX_NUM_CH_LOG2;

    logic [`MIX_NUM_CH-1:0] fifo_push;
    logic [`MIX_NUM_CH-1:0] fifo_pop;
    mixer_pkg::sample_t     fifo_head [0:`MIX_NUM_CH-1];
    mixer_pkg::vol_pair_t   vol_pair [0:`MIX_NUM_CH-1];

    generate
        for (genvar g = 0; g < `MIX_NUM_CH; g++) begin : g_src
            // only the FIFO named by the source index sees the push.
            assign fifo_push[g] = src_push_i.valid && (src_push_i.src == SRC_W'(g));

            src_fifo i_fifo (
                .clk      (clk),
                .rst      (rst),
                .push_i   (fifo_push[g]),
                .sample_i (src_push_i.data),
                .pop_i    (fifo_pop[g]),
                .head_o   (fifo_head[g]),
                .full_o   (src_full_o[g])
            );
        end
    endgenerate

    vol_regs i_vol_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .vol_o    (vol_pair)
    );

    mixer i_mixer (
        .clk    (clk),
        .rst    (rst),
        .pop_o  (fifo_pop),
        .data_i (fifo_head),
        .vol_i  (vol_pair),
        .pop_i  (snk_pop_i),
        .data_o (snk_data_o),
        .ack_o  (snk_ack_o)
    );

endmodule

//--- tests/mixer_tb.sv
`timescale 1ns/10ps
`include "mixer_defines.svh"

module mixer_tb;

    localparam int MAX_OPS    = 64;
    localparam int MAX_FRAMES = 32;

    logic                   clk;
    logic                   rst;
    mixer_pkg::wb_req_t     wb_req;
    mixer_pkg::wb_rsp_t     wb_rsp;
    mixer_pkg::src_push_t   src_push;
    logic [`MIX_NUM_CH-1:0] src_full;
    logic [1:0]             snk_pop;
    mixer_pkg::sample_t     snk_data;
    logic [1:0]             snk_ack;

    int          fd;
    int          checks;
    int          errors;
    int          frame_clk;
    int          wd_cycles;
    int          limit_cycles;
    int          n_ops;
    int          n_frames;
    int          op_frame [0:MAX_OPS-1];
    logic [7:0]  op_kind [0:MAX_OPS-1];
    int          op_a [0:MAX_OPS-1];
    int          op_b [0:MAX_OPS-1];
    int          op_c [0:MAX_OPS-1];
    bit          exp_valid [0:MAX_FRAMES-1];
    logic [23:0] exp_left [0:MAX_FRAMES-1];
    logic [23:0] exp_right [0:MAX_FRAMES-1];
    int          fill [0:`MIX_NUM_CH-1]; // expected occupancy of each source FIFO.

    mixer_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .wb_req_i   (wb_req),
        .wb_rsp_o   (wb_rsp),
        .src_push_i (src_push),
        .src_full_o (src_full),
        .snk_pop_i  (snk_pop),
        .snk_data_o (snk_data),
        .snk_ack_o  (snk_ack)
    );

    always #10 clk = ~clk;

    // after the n-th edge past reset this equals the mixer's absolute phase.
    always @(posedge clk) begin
        if (!rst) begin
            frame_clk <= frame_clk + 1;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycle(input int n);
        while (frame_clk < n) begin
            @(negedge clk);
        end
    endtask

    task automatic bus_access(input logic write_en, input int adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write_en, adr: `MIX_WB_AW'(adr), dat: wdata};
        @(negedge clk);
        check({31'd0, wb_rsp.ack}, 32'd0, "wishbone ack in the request clock");
        @(posedge clk);
        @(negedge clk);
        check({31'd0, wb_rsp.ack}, 32'd1, $sformatf("wishbone ack for address %0d", adr));
        rdata = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0; // stb drops once ack has been seen.
        @(negedge clk);
        check({31'd0, wb_rsp.ack}, 32'd0, "wishbone ack lasting one clock");
    endtask

    task automatic set_volume(input int src, input logic [15:0] left, input logic [15:0] right);
        mixer_pkg::vol_pair_t pair;
        logic [31:0]          rdata;
        pair = '{right: right, left: left};
        bus_access(1'b1, src, pair, rdata);
        bus_access(1'b0, src, 32'd0, rdata);
        check(rdata, pair, $sformatf("volume readback of source %0d", src));
    endtask

    task automatic push_sample(input int src, input logic [23:0] sample);
        logic exp_full;
        @(negedge clk);
        exp_full = (fill[src] == `MIX_FIFO_DEPTH);
        check({31'd0, src_full[src]}, {31'd0, exp_full}, $sformatf("full flag of source %0d", src));
        @(posedge clk);
        src_push <= '{valid: 1'b1, src: `MIX_NUM_CH_LOG2'(src), data: sample};
        @(posedge clk);
        src_push <= '0;
        if (!exp_full) begin
            fill[src]++; // a push to a full FIFO is dropped.
        end
    endtask

    task automatic pop_sink(input logic [1:0] req, input logic [1:0] exp_ack,
                            input logic [23:0] exp_data, input int frame);
        @(posedge clk);
        snk_pop <= req;
        @(posedge clk);
        snk_pop <= 2'b00;
        @(negedge clk);
        check({30'd0, snk_ack}, {30'd0, exp_ack}, $sformatf("sink ack for pop %b", req));
        check({8'd0, snk_data}, {8'd0, exp_data},
              $sformatf("frame %0d output for pop %b", frame, req));
    endtask

    task automatic read_stim();
        int         r;
        int         ch;
        int         a;
        int         b;
        int         c;
        int         cur;
        logic [7:0] kind;
        cur = -1;
        r = $fscanf(fd, " %c", kind);
        while (r == 1) begin
            if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (kind == "E") begin
                r = $fscanf(fd, "%d %h %h", a, b, c);
                if (a < 0 || a >= MAX_FRAMES) begin
                    $display("the stimulus file names frame %0d, which is out of range", a);
                    errors++;
                end else begin
                    cur = a; // the V and S lines that follow belong to this frame.
                    exp_valid[a] = 1'b1;
                    exp_left[a] = b[23:0];
                    exp_right[a] = c[23:0];
                    n_frames = (a + 1 > n_frames) ? a + 1 : n_frames;
                end
            end else if ((kind == "V" || kind == "S") && n_ops < MAX_OPS) begin
                c = 0;
                if (kind == "V") begin
                    r = $fscanf(fd, "%d %h %h", a, b, c);
                end else begin
                    r = $fscanf(fd, "%d %h", a, b);
                end
                op_frame[n_ops] = cur;
                op_kind[n_ops] = kind;
                op_a[n_ops] = a;
                op_b[n_ops] = b;
                op_c[n_ops] = c;
                n_ops++;
            end else begin
                $display("the stimulus file holds an unknown or excess record of kind %c", kind);
                errors++;
            end
            r = $fscanf(fd, " %c", kind);
        end
    endtask

    task automatic run_tests();
        logic [31:0] rdata;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < `MIX_NUM_CH; s++) begin
            bus_access(1'b0, s, 32'd0, rdata);
            check(rdata, 32'h8000_8000, $sformatf("reset volume of source %0d", s));
        end
        // frame g loads the volumes and samples of frame g+1 and reads the result of g-1.
        for (int g = 0; g <= n_frames; g++) begin
            wait_cycle(g * `MIX_FS + 32);
            for (int s = 0; s < `MIX_NUM_CH; s++) begin
                if (g > 0 && fill[s] > 0) begin
                    fill[s]--;
                end
            end
            for (int i = 0; i < n_ops; i++) begin
                if (op_frame[i] == g + 1 && op_kind[i] == "V") begin
                    set_volume(op_a[i], op_b[i][15:0], op_c[i][15:0]);
                end else if (op_frame[i] == g + 1) begin
                    push_sample(op_a[i], op_b[i][23:0]);
                end
            end
            wait_cycle(g * `MIX_FS + 160);
            if (g > 0 && exp_valid[g - 1]) begin
                pop_sink(2'b01, 2'b01, exp_left[g - 1], g - 1);
                pop_sink(2'b10, 2'b10, exp_right[g - 1], g - 1);
                pop_sink(2'b11, 2'b01, exp_left[g - 1], g - 1);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wb_req = '0;
        src_push = '0;
        snk_pop = 2'b00;
        fd = $fopen("tests/mixer_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/mixer_stim.txt");
            $display("Checks failed");
            $finish;
        end else begin
            read_stim();
            $fclose(fd);
            limit_cycles = (n_frames + 4) * `MIX_FS + 200;
            run_tests();
            $display("checks run: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    initial begin
        @(posedge clk);
        while (wd_cycles < limit_cycles) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tests/mixer_stim.txt
# E frame left right opens a frame; V source left right and S source sample belong to it.
# sources and frames are decimal, the rest is hex; V and S are applied one frame earlier.
E 0 000000 000000
E 1 000a00 000a00
S 0 000100
S 1 000200
S 2 000300
S 3 000400
E 2 0fff9f efffc0
V 0 8000 0000
V 1 0000 8000
V 2 4000 2000
V 3 ffff 0001
S 0 100000
S 1 f00000
S 2 ffff00
S 3 000010
E 3 500001 900001
V 0 8000 8000
V 1 8000 8000
V 2 8000 4000
V 3 8000 8000
S 0 700000
S 1 600000
S 2 800000
S 3 000001
E 4 000011 000011
V 2 8000 8000
S 0 000011
S 0 000022
S 0 000033
S 0 000044
S 0 000055
E 5 000022 000022
E 6 000033 000033
E 7 000044 000044
E 8 123456 000000
V 1 8000 0000
S 1 123456

//--- flist.f
+incdir+hw
hw/mixer_pkg.sv
hw/mpemu_scale.sv
hw/src_fifo.sv
hw/vol_regs.sv
hw/mixer.sv
hw/mixer_top.sv
tests/mixer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the mixer testbench; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module mixer_tb -f flist.f -o mixer_sim \
    && ./obj_dir/mixer_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && exit 0 || exit 1
